// File: Makefile
TOP = tb_rv_display_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): rv_display_top.f $(wildcard src/*.sv src/*.svh tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f rv_display_top.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module rv_display_top -f rv_display_top.f

clean:
	rm -rf obj_dir

// File: rv_display_top.f
+incdir+src
src/rv_pkg.sv
src/rv_control_fsm.sv
src/rv_progress_counters.sv
src/rv_fetch_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_hex_display.sv
src/rv_display_top.sv
tb/tb_clock_gen.sv
tb/tb_rv_display_top.sv

// File: src/rv_alu.sv
`default_nettype none

module rv_alu
	import rv_pkg::*;
(
	input  alu_op_e     alu_op,
	input  logic        use_imm,
	input  logic        use_pc,
	input  logic [31:0] rs1_data,
	input  logic [31:0] rs2_data,
	input  logic [31:0] pc,
	input  logic [31:0] imm,
	output logic [31:0] result,
	output logic        branch_taken
);

	logic [31:0] op_a;
	logic [31:0] op_b;

	assign op_a = use_pc ? pc : rs1_data;
	assign op_b = use_imm ? imm : rs2_data;

	always_comb begin
		case (alu_op)
			alu_sub:    result = op_a - op_b;
			alu_and:    result = op_a & op_b;
			alu_or:     result = op_a | op_b;
			alu_xor:    result = op_a ^ op_b;
			alu_pass_b: result = op_b;
			alu_link:   result = op_a + 32'd4; // return address.
			default:    result = op_a + op_b;
		endcase
	end

	assign branch_taken = ((alu_op == alu_beq) && (op_a == op_b)) ||
	                      ((alu_op == alu_bne) && (op_a != op_b));

endmodule

`default_nettype wire

// File: src/rv_control_fsm.sv
`default_nettype none

module rv_control_fsm
	import rv_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       run,
	input  rv_opcode_e opcode,
	input  logic       branch_taken,
	output logic       ir_load,
	output logic       rf_we,
	output logic       pc_advance,
	output logic       pc_load,
	output logic       retire,
	output logic       halted
);

	cpu_state_e state;
	cpu_state_e state_nxt;
	logic       in_wb;
	logic       writes_rd;
	logic       redirect;

	////////////////////////////////////////
	// state sequencing
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:      if (run) state_nxt = st_fetch;
			st_fetch:     state_nxt = st_decode;
			st_decode:    state_nxt = st_execute;
			st_execute:   state_nxt = (opcode == op_system) ? st_halt : st_writeback;
			st_writeback: state_nxt = st_fetch;
			st_halt:      state_nxt = st_halt; // held until reset.
			default:      state_nxt = st_idle;
		endcase
	end

	////////////////////////////////////////
	// strobes
	////////////////////////////////////////
	assign in_wb     = (state == st_writeback);
	assign writes_rd = (opcode == op_reg) || (opcode == op_imm) ||
	                   (opcode == op_lui) || (opcode == op_jal); // branches write nothing.
	assign redirect  = (opcode == op_jal) || ((opcode == op_branch) && branch_taken);

	assign ir_load    = (state == st_fetch);
	assign rf_we      = in_wb && writes_rd;
	assign pc_load    = in_wb && redirect;
	assign pc_advance = in_wb && !redirect;
	assign retire     = in_wb;
	assign halted     = (state == st_halt);

	a_pc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		!(pc_advance && pc_load));

	// only the kept RV32I subset reaches execute.
	a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_execute) |->
			(opcode inside {op_reg, op_imm, op_lui, op_branch, op_jal, op_system}));

endmodule

`default_nettype wire

// File: src/rv_display_top.sv
`default_nettype none

module rv_display_top
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,
	input  logic        prog_we,
	input  logic [5:0]  prog_addr,
	input  logic [31:0] prog_data,
	input  logic [3:0]  sw,
	output logic        halted,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3,
	output logic [6:0]  hex4,
	output logic [6:0]  hex5
);

	rv_opcode_e  opcode;
	alu_op_e     alu_op;
	logic        branch_taken;
	logic        ir_load;
	logic        rf_we;
	logic        pc_advance;
	logic        pc_load;
	logic        retire;
	logic        use_imm;
	logic        use_pc;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [4:0]  rd_addr;
	logic [4:0]  view_addr;
	logic [31:0] pc;
	logic [31:0] retired;
	logic [31:0] instr;
	logic [31:0] imm;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] result;

	////////////////////////////////////////
	// core
	////////////////////////////////////////
	rv_control_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .run(run), .opcode(opcode),
		.branch_taken(branch_taken), .ir_load(ir_load), .rf_we(rf_we),
		.pc_advance(pc_advance), .pc_load(pc_load), .retire(retire), .halted(halted)
	);

	rv_progress_counters u_counters (
		.clk(clk), .rst_n(rst_n), .pc_advance(pc_advance), .pc_load(pc_load),
		.retire(retire), .imm(imm), .pc(pc), .pc_plus4(), .retired(retired)
	);

	rv_fetch_decode u_fetch (
		.clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .pc(pc), .ir_load(ir_load), .view_addr(view_addr),
		.halted(halted), .instr(instr), .opcode(opcode), .rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr), .rd_addr(rd_addr), .imm(imm), .alu_op(alu_op),
		.use_imm(use_imm), .use_pc(use_pc)
	);

	rv_regfile u_regs (
		.clk(clk), .rst_n(rst_n), .we(rf_we), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rd_addr(rd_addr), .wdata(result), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu u_alu (
		.alu_op(alu_op), .use_imm(use_imm), .use_pc(use_pc), .rs1_data(rs1_data),
		.rs2_data(rs2_data), .pc(pc), .imm(imm), .result(result),
		.branch_taken(branch_taken)
	);

	////////////////////////////////////////
	// board display
	////////////////////////////////////////
	rv_hex_display u_display (
		.sw(sw), .pc(pc), .instr(instr), .retired(retired), .view_reg(rs2_data),
		.view_addr(view_addr), .hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

endmodule

`default_nettype wire

// File: src/rv_fetch_decode.sv
`include "rv_params.svh"

`default_nettype none

module rv_fetch_decode
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        prog_we,
	input  logic [5:0]  prog_addr,
	input  logic [31:0] prog_data,
	input  logic [31:0] pc,
	input  logic        ir_load,
	input  logic [4:0]  view_addr,
	input  logic        halted,
	output logic [31:0] instr,
	output rv_opcode_e  opcode,
	output logic [4:0]  rs1_addr,
	output logic [4:0]  rs2_addr,
	output logic [4:0]  rd_addr,
	output logic [31:0] imm,
	output alu_op_e     alu_op,
	output logic        use_imm,
	output logic        use_pc
);

	logic [`RV_XLEN-1:0] imem [`RV_IMEM_DEPTH];
	logic [2:0]          funct3;
	logic                started;

	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr   <= '0;
			started <= 1'b0;
		end else if (ir_load) begin
			instr   <= imem[pc[7:2]];
			started <= 1'b1;
		end
	end

	////////////////////////////////////////
	// field extraction
	////////////////////////////////////////
	assign opcode   = rv_opcode_e'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign rd_addr  = instr[11:7];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = halted ? view_addr : instr[24:20]; // display borrows port 2.

	always_comb begin
		case (opcode)
			op_lui:    imm = {instr[31:12], 12'b0};
			op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
			                  instr[11:8], 1'b0};
			op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
			                  instr[30:21], 1'b0};
			default:   imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	always_comb begin
		alu_op  = alu_add;
		use_imm = 1'b0;
		use_pc  = 1'b0;
		case (opcode)
			op_reg: begin
				case (funct3)
					3'b000:  alu_op = instr[30] ? alu_sub : alu_add;
					3'b100:  alu_op = alu_xor;
					3'b110:  alu_op = alu_or;
					3'b111:  alu_op = alu_and;
					default: alu_op = alu_add;
				endcase
			end
			op_imm: use_imm = 1'b1; // addi only.
			op_lui: begin
				alu_op  = alu_pass_b;
				use_imm = 1'b1;
			end
			op_branch: alu_op = funct3[0] ? alu_bne : alu_beq;
			op_jal: begin
				alu_op = alu_link;
				use_pc = 1'b1;
			end
			default: alu_op = alu_add;
		endcase
	end

	// program loading only before the core has started.
	a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
		prog_we |-> !started && !ir_load && !halted);

endmodule

`default_nettype wire

// File: src/rv_hex_display.sv
`include "rv_params.svh"

`default_nettype none

module rv_hex_display
	import rv_pkg::*;
(
	input  logic [3:0]  sw,
	input  logic [31:0] pc,
	input  logic [31:0] instr,
	input  logic [31:0] retired,
	input  logic [31:0] view_reg,
	output logic [4:0]  view_addr,
	output logic [6:0]  hex0,
	output logic [6:0]  hex1,
	output logic [6:0]  hex2,
	output logic [6:0]  hex3,
	output logic [6:0]  hex4,
	output logic [6:0]  hex5
);

	disp_sel_e           sel;
	logic [`RV_XLEN-1:0] shown;
	logic [6:0]          seg [`RV_HEX_DIGITS];

	// active low, gfedcba.
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	assign sel       = disp_sel_e'(sw[3:2]);
	assign view_addr = {3'b010, sw[1:0]}; // x8 to x11.

	always_comb begin
		case (sel)
			disp_pc:      shown = pc;
			disp_instr:   shown = instr;
			disp_retired: shown = retired;
			default:      shown = view_reg;
		endcase
	end

	always_comb begin
		for (int d = 0; d < `RV_HEX_DIGITS; d++) begin
			seg[d] = hex_to_seg(shown[d*4 +: 4]);
		end
	end

	assign hex0 = seg[0];
	assign hex1 = seg[1];
	assign hex2 = seg[2];
	assign hex3 = seg[3];
	assign hex4 = seg[4];
	assign hex5 = seg[5];

endmodule

`default_nettype wire

// File: src/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`default_nettype none

// core data path width.
`define RV_XLEN 32

// instruction words, indexed by pc[7:2].
`define RV_IMEM_DEPTH 64

// seven-segment digits on the board.
`define RV_HEX_DIGITS 6

`default_nettype wire

`endif

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_decode,
		st_execute,
		st_writeback,
		st_halt
	} cpu_state_e;

	// base opcodes, RV32I encodings.
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_lui    = 7'b0110111,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_system = 7'b1110011
	} rv_opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b,
		alu_beq,
		alu_bne,
		alu_link
	} alu_op_e;

	typedef enum logic [1:0] {
		disp_pc,
		disp_instr,
		disp_retired,
		disp_reg
	} disp_sel_e;

endpackage

`default_nettype wire

// File: src/rv_progress_counters.sv
`default_nettype none

module rv_progress_counters
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pc_advance,
	input  logic        pc_load,
	input  logic        retire,
	input  logic [31:0] imm,
	output logic [31:0] pc,
	output logic [31:0] pc_plus4,
	output logic [31:0] retired
);

	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			retired <= '0;
		end else begin
			if (pc_advance) begin
				pc <= pc_plus4;
			end else if (pc_load) begin
				pc <= pc + imm; // branch or jal target.
			end
			if (retire) begin
				retired <= retired + 32'd1; // wraps.
			end
		end
	end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`include "rv_params.svh"

`default_nettype none

module rv_regfile
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	input  logic [4:0]  rd_addr,
	input  logic [31:0] wdata,
	output logic [31:0] rs1_data,
	output logic [31:0] rs2_data
);

	logic [`RV_XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= wdata; // x0 never written.
		end
	end

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: tb/rv_stim.txt
# P <instruction word hex> | R <expected retired count hex>
# E <sw hex> <expected 24-bit display value hex>
P 00500093  addi x1, x0, 5
P 12345137  lui  x2, 0x12345
P 67810113  addi x2, x2, 0x678
P 0f000193  addi x3, x0, 0xf0
P 00208433  add  x8, x1, x2
P 401104b3  sub  x9, x2, x1
P 00317533  and  x10, x2, x3
P 00156533  or   x10, x10, x1
P 00354533  xor  x10, x10, x3
P 05508013  addi x0, x1, 0x55 (x0 stays zero)
P 400484b3  sub  x9, x9, x0
P 00108463  beq  x1, x1, +8 (taken)
P 00148493  addi x9, x9, 1 (skipped)
P 00109463  bne  x1, x1, +8 (not taken)
P 00140413  addi x8, x8, 1 (executed)
P 008005ef  jal  x11, +8
P 00248493  addi x9, x9, 2 (skipped)
P 00000073  ecall at 0x44
R 0000000f
E 0 000044
E 4 000073
E c 34567e
E d 345673
E e 000085
E f 000040

// File: tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_rv_display_top.sv
`default_nettype none

module tb_rv_display_top;

	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        prog_we;
	logic [5:0]  prog_addr;
	logic [31:0] prog_data;
	logic [3:0]  sw;
	logic        halted;
	logic [6:0]  hex0;
	logic [6:0]  hex1;
	logic [6:0]  hex2;
	logic [6:0]  hex3;
	logic [6:0]  hex4;
	logic [6:0]  hex5;

	logic [31:0] prog_q [$];
	logic [3:0]  view_sw_q [$];
	logic [23:0] view_exp_q [$];
	logic [31:0] exp_retired;
	logic        run_started;

	tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

	rv_display_top DUT (
		.clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .sw(sw), .halted(halted), .hex0(hex0), .hex1(hex1),
		.hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// bit 4 set for a pattern outside the glyph table.
	function automatic logic [4:0] seg_to_nibble(input logic [6:0] seg);
		case (seg)
			7'b1000000: return 5'h00;
			7'b1111001: return 5'h01;
			7'b0100100: return 5'h02;
			7'b0110000: return 5'h03;
			7'b0011001: return 5'h04;
			7'b0010010: return 5'h05;
			7'b0000010: return 5'h06;
			7'b1111000: return 5'h07;
			7'b0000000: return 5'h08;
			7'b0010000: return 5'h09;
			7'b0001000: return 5'h0a;
			7'b0000011: return 5'h0b;
			7'b1000110: return 5'h0c;
			7'b0100001: return 5'h0d;
			7'b0000110: return 5'h0e;
			7'b0001110: return 5'h0f;
			default:    return 5'h10;
		endcase
	endfunction

	task automatic check_view(input logic [3:0] view, input logic [23:0] exp,
		input string what);
		logic [4:0]  dig [6];
		logic [23:0] shown;
		logic [5:0]  bad;
		int          d;
		@(posedge clk);
		sw <= view;
		@(posedge clk);
		@(negedge clk); // display settled.
		dig[0] = seg_to_nibble(hex0);
		dig[1] = seg_to_nibble(hex1);
		dig[2] = seg_to_nibble(hex2);
		dig[3] = seg_to_nibble(hex3);
		dig[4] = seg_to_nibble(hex4);
		dig[5] = seg_to_nibble(hex5);
		for (d = 0; d < 6; d++) begin
			shown[d*4 +: 4] = dig[d][3:0];
			bad[d]          = dig[d][4];
		end
		check_value({26'b0, bad}, 32'h0, $sformatf("%s, unknown glyph, sw %h", what, view));
		check_value({8'h0, shown}, {8'h0, exp}, $sformatf("%s, sw %h", what, view));
	endtask

	task automatic read_stim();
		int          fd;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("tb/rv_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/rv_stim.txt");
			$display("ERRORS FOUND");
			$fatal(1, "missing stimulus file");
		end
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "P %h", a) == 1) begin
				prog_q.push_back(a);
			end else if ($sscanf(line, "R %h", a) == 1) begin
				exp_retired = a;
			end else if ($sscanf(line, "E %h %h", a, b) == 2) begin
				view_sw_q.push_back(a[3:0]);
				view_exp_q.push_back(b[23:0]);
			end
		end
		$fclose(fd);
	endtask

	task automatic load_program();
		int i;
		if (prog_q.size() == 0 || prog_q.size() > 64) begin
			$display("program in tb/rv_stim.txt is empty or larger than 64 words");
			$display("ERRORS FOUND");
			$fatal(1, "bad program length");
		end
		for (i = 0; i < prog_q.size(); i++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= i[5:0];
			prog_data <= prog_q[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		int          cycles;
		logic [31:0] exp_cycles;
		int          v;
		run         = 1'b0;
		prog_we     = 1'b0;
		prog_addr   = '0;
		prog_data   = '0;
		sw          = '0;
		run_started = 1'b0;
		exp_retired = '0;
		read_stim();
		wait (rst_n === 1'b1);

		for (v = 0; v < 8; v++) begin
			check_view(v[3:0], 24'h0, "idle view");
		end
		check_value({31'b0, halted}, 32'd0, "halted before run");

		load_program();
		@(posedge clk);
		run <= 1'b1;
		run_started = 1'b1;
		@(posedge clk);
		run <= 1'b0; // seen by the FSM at this edge.

		cycles = 0;
		@(negedge clk);
		while (!halted) begin
			cycles++;
			@(negedge clk);
		end
		// four per retired instruction, plus fetch, decode and execute of the ecall.
		exp_cycles = 4 * exp_retired + 3;
		check_value(cycles, exp_cycles, "cycles from run to halted");

		check_view(4'h8, exp_retired[23:0], "retired count");
		for (v = 0; v < view_sw_q.size(); v++) begin
			check_view(view_sw_q[v], view_exp_q[v], "view after halt");
		end
		check_value({31'b0, halted}, 32'd1, "halted held after the views");

		if (view_sw_q.size() > 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("no display checks were found in tb/rv_stim.txt");
			$display("ERRORS FOUND");
			$fatal(1, "nothing checked after the halt");
		end
	end

	// bounds the run by the program length.
	initial begin
		wait (run_started);
		repeat (4 * (prog_q.size() + 20)) @(posedge clk);
		if (!halted) begin
			$display("watchdog expired, halted never rose");
		end else begin
			$display("watchdog expired, display checks did not finish after the halt");
		end
		$display("ERRORS FOUND");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire
